// File: run_sim.sh
#!/bin/sh
# Verilator build and run for the HDMI TMDS testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f \
    --top-module tb_hdmi_tmds_tx -Mdir obj_dir -o tb_hdmi_tmds_tx
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_hdmi_tmds_tx > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0

// File: test/tb_hdmi_tmds_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HDMI TMDS testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_hdmi_tmds_tx
    import hdmi_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Sampling edge to output edge with default PREAMBLE_LEN and GUARD_LEN
    localparam int    LATENCY   = 8 + 2 + 2;
    localparam string TEST_FILE = "test/tmds_tests.txt";
    localparam tmds_symbols_t IDLE_SYMBOLS =
        '{ch2: 10'b1101010100, ch1: 10'b1101010100, ch0: 10'b1101010100};

    logic          clk_pixel;
    logic          rst_n;
    pixel_timing_t pixel_in;
    tmds_symbols_t tmds;

    pixel_timing_t stim_q[$];
    tmds_symbols_t expected_q[$];
    tmds_symbols_t pending_q[$];
    int            error_count;
    int            check_count;
    int            watchdog_ns;

    hdmi_tmds_tx dut (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .pixel_in  (pixel_in),
        .tmds      (tmds)
    );

    initial
        clk_pixel = 1'b0;

    always #50 clk_pixel = ~clk_pixel;

    task automatic check_symbol(input string label, input tmds_word_t got,
                                input tmds_word_t exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("CHECK FAILED at %0d ns: %s got %b expected %b", $time, label, got, exp);
        end
    endtask

    task automatic compare_lanes(input tmds_symbols_t got, input tmds_symbols_t exp);
        check_symbol("tmds.ch0", got.ch0, exp.ch0);
        check_symbol("tmds.ch1", got.ch1, exp.ch1);
        check_symbol("tmds.ch2", got.ch2, exp.ch2);
    endtask

    // One pixel per data line with fields and expected symbols in binary
    task automatic load_tests();
        int            fd;
        int            n;
        int            line_no;
        string         line;
        logic [7:0]    red;
        logic [7:0]    green;
        logic [7:0]    blue;
        logic          hs;
        logic          vs;
        logic          va;
        logic          ia;
        logic [3:0]    n2;
        logic [3:0]    n1;
        logic [3:0]    n0;
        tmds_word_t    e0;
        tmds_word_t    e1;
        tmds_word_t    e2;
        pixel_timing_t px;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0)
        begin
            $display("Error: cannot open test file %s", TEST_FILE);
            error_count++;
            return;
        end
        line_no = 0;
        while ($fgets(line, fd) != 0)
        begin
            line_no++;
            if (line.len() <= 1 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%b %b %b %b %b %b %b %b %b %b %b %b %b",
                        red, green, blue, hs, vs, va, ia, n2, n1, n0, e0, e1, e2);
            if (n != 13)
            begin
                $display("Error: malformed line %0d in test file", line_no);
                error_count++;
            end
            else
            begin
                px.red           = red;
                px.green         = green;
                px.blue          = blue;
                px.hsync         = hs;
                px.vsync         = vs;
                px.video_active  = va;
                px.island_active = ia;
                px.island_data   = {n2, n1, n0};
                stim_q.push_back(px);
                expected_q.push_back('{ch2: e2, ch1: e1, ch0: e0});
            end
        end
        $fclose(fd);
        if (stim_q.size() == 0)
        begin
            $display("Error: test file holds no data lines");
            error_count++;
        end
    endtask

    // Outputs sit at the reset control symbol throughout
    task automatic apply_reset();
        repeat (4)
        begin
            @(posedge clk_pixel);
            #1;
            compare_lanes(tmds, IDLE_SYMBOLS);
        end
        rst_n = 1'b1;
    endtask

    // Line i is driven here and checked LATENCY+1 iterations later
    task automatic run_tests();
        tmds_symbols_t expected;
        for (int i = 0; i < stim_q.size() + LATENCY + 1; i++)
        begin
            if (i > LATENCY)
            begin
                expected = pending_q.pop_front();
                compare_lanes(tmds, expected);
            end
            if (i < stim_q.size())
            begin
                pixel_in = stim_q[i];
                pending_q.push_back(expected_q[i]);
            end
            else
                pixel_in = '0;
            @(posedge clk_pixel);
            #1;
        end
    endtask

    initial
    begin : watchdog
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("Timeout: run did not finish within %0d ns", watchdog_ns);
        $display("Checks: %0d  Errors: %0d", check_count, error_count);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin : main
        rst_n       = 1'b0;
        pixel_in    = '0;
        error_count = 0;
        check_count = 0;
        load_tests();
        if (stim_q.size() != 0)
        begin
            watchdog_ns = (stim_q.size() + 4 + 20) * 100;
            apply_reset();
            run_tests();
        end
        $display("Checks: %0d  Errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: test/tmds_tests.txt
# One pixel clock per line, all values binary
# red green blue hsync vsync video_active island_active nib2 nib1 nib0 exp_ch0 exp_ch1 exp_ch2
# Idle and control coding of the sync bits
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 1101010100 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 1101010100 1101010100
00000000 00000000 00000000 1 0 0 0 0000 0000 0000 0010101011 1101010100 1101010100
00000000 00000000 00000000 0 1 0 0 0000 0000 0000 0101010100 1101010100 1101010100
00000000 00000000 00000000 1 1 0 0 0000 0000 0000 1010101011 1101010100 1101010100
11111111 10101010 01010101 0 0 0 0 1111 1111 1111 1101010100 1101010100 1101010100
# Video preamble and leading guard band
00000000 00000000 00000000 1 0 0 0 0000 0000 0000 0010101011 0010101011 1101010100
00000000 00000000 00000000 1 0 0 0 0000 0000 0000 0010101011 0010101011 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1011001100 0100110011 1011001100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1011001100 0100110011 1011001100
# First video period, includes bytes with four ones
10100101 00010000 00000000 0 0 1 0 0000 0000 0000 0100000000 0111110000 0101100011
00111100 11000011 11111111 0 0 1 0 0000 0000 0000 0011111111 0101000001 1001000001
10000000 01100110 00001111 0 0 1 0 0000 0000 0000 1111111010 1001110111 1101111111
01111110 00000001 11110000 0 0 1 0 0000 0000 0000 1000000101 0111111111 0010000000
# Minimum gap before the next video period
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1011001100 0100110011 1011001100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1011001100 0100110011 1011001100
# Second video period, disparity starts again from zero
10100101 00010000 00000001 0 0 1 0 0000 0000 0000 0111111111 0111110000 0101100011
00111100 11000011 11111110 0 0 1 0 0000 0000 0000 0000000000 0101000001 1001000001
# Island preamble and leading guard band
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 0010101011
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 0010101011
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 0010101011
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 0010101011
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 0010101011
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 0010101011
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 0010101011
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 0010101011 0010101011
00000000 00000000 00000000 1 0 0 0 0000 0000 0000 1001110001 0100110011 0100110011
00000000 00000000 00000000 0 1 0 0 0000 0000 0000 0101100011 0100110011 0100110011
# Data island, TERC4 with sync bits on channel 0
00000000 00000000 00000000 1 0 0 1 0000 0001 1100 1001110001 1001100011 1010011100
00000000 00000000 00000000 0 0 0 1 1010 0111 0011 1010011100 0100111100 0110011100
00000000 00000000 00000000 0 1 0 1 1111 1000 1000 0110011100 1011001100 1011000011
00000000 00000000 00000000 1 1 0 1 0101 1110 0110 0100111100 0101100011 0100011110
# Trailing guard band, then control again
00000000 00000000 00000000 1 1 0 0 0000 0000 0000 1011000011 0100110011 0100110011
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1010001110 0100110011 0100110011
00000000 00000000 00000000 0 1 0 0 0000 0000 0000 0101010100 1101010100 1101010100
00000000 00000000 00000000 0 0 0 0 0000 0000 0000 1101010100 1101010100 1101010100

// File: verilog/hdmi_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HDMI TMDS shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package hdmi_pkg;

    // Per-channel symbol source
    typedef enum logic [2:0] {
        MODE_CONTROL      = 3'd0,
        MODE_VIDEO        = 3'd1,
        MODE_VIDEO_GUARD  = 3'd2,
        MODE_ISLAND       = 3'd3,
        MODE_ISLAND_GUARD = 3'd4
    } tmds_mode_t;

    typedef logic [9:0] tmds_word_t;

    // One source word per pixel clock
    typedef struct packed {
        logic [7:0]      red;
        logic [7:0]      green;
        logic [7:0]      blue;
        logic            hsync;
        logic            vsync;
        logic            video_active;
        logic            island_active;
        // Nibble index matches channel number
        logic [2:0][3:0] island_data;
    } pixel_timing_t;

    typedef struct packed {
        tmds_mode_t mode;
        logic [7:0] video_data;
        logic [3:0] island_nibble;
        logic [1:0] control_data;
    } channel_cmd_t;

    typedef struct packed {
        channel_cmd_t ch2;
        channel_cmd_t ch1;
        channel_cmd_t ch0;
    } channel_cmds_t;

    typedef struct packed {
        tmds_word_t ch2;
        tmds_word_t ch1;
        tmds_word_t ch0;
    } tmds_symbols_t;

    // CTL3..CTL0 during the control-period preamble
    localparam logic [3:0] CTL_VIDEO_PREAMBLE  = 4'b0001;
    localparam logic [3:0] CTL_ISLAND_PREAMBLE = 4'b0101;

endpackage

// File: verilog/hdmi_tmds_tx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HDMI TMDS transmitter top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module hdmi_tmds_tx
    import hdmi_pkg::*;
#(
    parameter int PREAMBLE_LEN = 8,
    parameter int GUARD_LEN    = 2
)
(
    input  logic          clk_pixel,
    input  logic          rst_n,
    input  pixel_timing_t pixel_in,
    output tmds_symbols_t tmds
);

    channel_cmds_t cmds;
    tmds_word_t    sym0;
    tmds_word_t    sym1;
    tmds_word_t    sym2;

    period_sequencer #(
        .PREAMBLE_LEN (PREAMBLE_LEN),
        .GUARD_LEN    (GUARD_LEN)
    ) u_sequencer (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .pixel_in  (pixel_in),
        .cmds      (cmds)
    );

    // Blue, green and red lanes
    tmds_channel #(.CN(0)) u_channel0 (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .cmd       (cmds.ch0),
        .tmds      (sym0)
    );

    tmds_channel #(.CN(1)) u_channel1 (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .cmd       (cmds.ch1),
        .tmds      (sym1)
    );

    tmds_channel #(.CN(2)) u_channel2 (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .cmd       (cmds.ch2),
        .tmds      (sym2)
    );

    assign tmds = '{ch2: sym2, ch1: sym1, ch0: sym0};

endmodule

// File: verilog/period_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HDMI period sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module period_sequencer
    import hdmi_pkg::*;
#(
    parameter int PREAMBLE_LEN = 8,
    parameter int GUARD_LEN    = 2
)
(
    input  logic          clk_pixel,
    input  logic          rst_n,
    input  pixel_timing_t pixel_in,
    output channel_cmds_t cmds
);

    localparam int LEAD = PREAMBLE_LEN + GUARD_LEN;
    localparam int DW   = $clog2(LEAD + 1);
    localparam int GW   = $clog2(GUARD_LEN + 1);

    // pipe[LEAD] is the word being classified, pipe[LEAD-k] is k cycles ahead
    pixel_timing_t pipe [LEAD+1];
    pixel_timing_t cur;

    logic [GW-1:0] trail_cnt;
    logic          vid_found;
    logic          isl_found;
    logic [DW-1:0] vid_dist;
    logic [DW-1:0] isl_dist;
    tmds_mode_t    mode_next;
    logic [3:0]    ctl_next;
    channel_cmds_t cmds_next;

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i <= LEAD; i++)
                pipe[i] <= '0;
        end
        else
        begin
            pipe[0] <= pixel_in;
            for (int i = 1; i <= LEAD; i++)
                pipe[i] <= pipe[i-1];
        end
    end

    assign cur = pipe[LEAD];

    // Scan far to near, so the nearest start is the one left standing
    always_comb
    begin
        vid_found = 1'b0;
        isl_found = 1'b0;
        vid_dist  = '0;
        isl_dist  = '0;
        for (int k = LEAD; k >= 1; k--)
        begin
            if (pipe[LEAD-k].video_active)
            begin
                vid_found = 1'b1;
                vid_dist  = DW'(k);
            end
            if (pipe[LEAD-k].island_active)
            begin
                isl_found = 1'b1;
                isl_dist  = DW'(k);
            end
        end
    end

    // Period classification of the oldest word
    always_comb
    begin
        mode_next = MODE_CONTROL;
        ctl_next  = 4'b0000;
        if (cur.video_active)
            mode_next = MODE_VIDEO;
        else if (cur.island_active)
            mode_next = MODE_ISLAND;
        else if (trail_cnt != '0)
            mode_next = MODE_ISLAND_GUARD;
        else if (vid_found && (!isl_found || vid_dist <= isl_dist))
        begin
            if (vid_dist <= DW'(GUARD_LEN))
                mode_next = MODE_VIDEO_GUARD;
            else
                ctl_next = CTL_VIDEO_PREAMBLE;
        end
        else if (isl_found)
        begin
            if (isl_dist <= DW'(GUARD_LEN))
                mode_next = MODE_ISLAND_GUARD;
            else
                ctl_next = CTL_ISLAND_PREAMBLE;
        end
    end

    // Channel 0 carries syncs, channels 1 and 2 carry CTL bits
    always_comb
    begin
        cmds_next.ch0.mode          = mode_next;
        cmds_next.ch0.video_data    = cur.blue;
        cmds_next.ch0.island_nibble = {cur.island_data[0][3:2], cur.vsync, cur.hsync};
        cmds_next.ch0.control_data  = {cur.vsync, cur.hsync};

        cmds_next.ch1.mode          = mode_next;
        cmds_next.ch1.video_data    = cur.green;
        cmds_next.ch1.island_nibble = cur.island_data[1];
        cmds_next.ch1.control_data  = ctl_next[1:0];

        cmds_next.ch2.mode          = mode_next;
        cmds_next.ch2.video_data    = cur.red;
        cmds_next.ch2.island_nibble = cur.island_data[2];
        cmds_next.ch2.control_data  = ctl_next[3:2];
    end

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            trail_cnt <= '0;
            cmds      <= '0;
        end
        else
        begin
            cmds <= cmds_next;
            // Reload while inside the island, count down once it ends
            if (cur.island_active)
                trail_cnt <= GW'(GUARD_LEN);
            else if (trail_cnt != '0)
                trail_cnt <= trail_cnt - 1'b1;
        end
    end

endmodule

// File: verilog/tmds_channel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TMDS channel encoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tmds_channel
    import hdmi_pkg::*;
#(
    parameter int CN = 0
)
(
    input  logic         clk_pixel,
    input  logic         rst_n,
    input  channel_cmd_t cmd,
    output tmds_word_t   tmds
);

    localparam tmds_word_t CTL_SYM_00      = 10'b1101010100;
    localparam tmds_word_t VIDEO_GUARD     = (CN == 1) ? 10'b0100110011 : 10'b1011001100;
    localparam tmds_word_t ISLAND_GUARD_12 = 10'b0100110011;

    logic [3:0]        n1_d;
    logic              use_xnor;
    logic [8:0]        q_m;
    logic [3:0]        n1_q;
    logic [3:0]        n0_q;
    logic signed [4:0] balance;
    logic signed [4:0] disp;
    logic signed [4:0] disp_next;
    tmds_word_t        video_sym;
    tmds_word_t        control_sym;
    tmds_word_t        terc4_sym;
    tmds_word_t        island_guard_sym;

    function automatic tmds_word_t terc4(input logic [3:0] nibble);
        case (nibble)
            4'b0000: terc4 = 10'b1010011100;
            4'b0001: terc4 = 10'b1001100011;
            4'b0010: terc4 = 10'b1011100100;
            4'b0011: terc4 = 10'b1011100010;
            4'b0100: terc4 = 10'b0101110001;
            4'b0101: terc4 = 10'b0100011110;
            4'b0110: terc4 = 10'b0110001110;
            4'b0111: terc4 = 10'b0100111100;
            4'b1000: terc4 = 10'b1011001100;
            4'b1001: terc4 = 10'b0100111001;
            4'b1010: terc4 = 10'b0110011100;
            4'b1011: terc4 = 10'b1011000110;
            4'b1100: terc4 = 10'b1010001110;
            4'b1101: terc4 = 10'b1001110001;
            4'b1110: terc4 = 10'b0101100011;
            default: terc4 = 10'b1011000011;
        endcase
    endfunction

    // Transition minimization stage
    always_comb
    begin : minimize
        logic [8:0] qm;
        n1_d     = 4'($countones(cmd.video_data));
        use_xnor = (n1_d > 4'd4) || (n1_d == 4'd4 && !cmd.video_data[0]);
        qm[0]    = cmd.video_data[0];
        for (int i = 1; i < 8; i++)
            qm[i] = use_xnor ? ~(qm[i-1] ^ cmd.video_data[i]) : (qm[i-1] ^ cmd.video_data[i]);
        qm[8]    = ~use_xnor;
        q_m      = qm;
    end

    // DC balance against running disparity
    always_comb
    begin
        n1_q    = 4'($countones(q_m[7:0]));
        n0_q    = 4'd8 - n1_q;
        balance = $signed({1'b0, n1_q}) - $signed({1'b0, n0_q});
        if (disp == 5'sd0 || n1_q == n0_q)
        begin
            video_sym = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disp_next = q_m[8] ? disp + balance : disp - balance;
        end
        else if ((disp > 5'sd0 && n1_q > n0_q) || (disp < 5'sd0 && n0_q > n1_q))
        begin
            video_sym = {1'b1, q_m[8], ~q_m[7:0]};
            disp_next = disp - balance + (q_m[8] ? 5'sd2 : 5'sd0);
        end
        else
        begin
            video_sym = {1'b0, q_m[8], q_m[7:0]};
            disp_next = disp + balance - (q_m[8] ? 5'sd0 : 5'sd2);
        end
    end

    always_comb
    begin
        case (cmd.control_data)
            2'b00:   control_sym = CTL_SYM_00;
            2'b01:   control_sym = 10'b0010101011;
            2'b10:   control_sym = 10'b0101010100;
            default: control_sym = 10'b1010101011;
        endcase
    end

    assign terc4_sym = terc4(cmd.island_nibble);

    // Channel 0 guard follows the sync bits, i.e. TERC4 codes 1100..1111
    assign island_guard_sym = (CN == 0) ? terc4({2'b11, cmd.control_data}) : ISLAND_GUARD_12;

    // Each video period starts from zero disparity
    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n || cmd.mode != MODE_VIDEO)
            disp <= '0;
        else
            disp <= disp_next;
    end

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
            tmds <= CTL_SYM_00;
        else
        begin
            case (cmd.mode)
                MODE_VIDEO:        tmds <= video_sym;
                MODE_VIDEO_GUARD:  tmds <= VIDEO_GUARD;
                MODE_ISLAND:       tmds <= terc4_sym;
                MODE_ISLAND_GUARD: tmds <= island_guard_sym;
                default:           tmds <= control_sym;
            endcase
        end
    end

endmodule

// File: vlog.f
verilog/hdmi_pkg.sv
verilog/period_sequencer.sv
verilog/tmds_channel.sv
verilog/hdmi_tmds_tx.sv
test/tb_hdmi_tmds_tx.sv
